// ==== logic/dispatch_config.svh ====
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// datapath sizes
`define DISPATCH_XLEN  32
`define DISPATCH_NREGS 32

// major opcodes of the supported RV32I subset
`define DISPATCH_OP_OP     7'b0110011
`define DISPATCH_OP_OP_IMM 7'b0010011
`define DISPATCH_OP_LOAD   7'b0000011
`define DISPATCH_OP_STORE  7'b0100011
`define DISPATCH_OP_BRANCH 7'b1100011
`define DISPATCH_OP_JAL    7'b1101111
`define DISPATCH_OP_JALR   7'b1100111
`define DISPATCH_OP_LUI    7'b0110111

// producer tags, 0 means the value sits in the register file
`define DISPATCH_TAG_NONE   2'd0
`define DISPATCH_TAG_ALU    2'd1
`define DISPATCH_TAG_BRANCH 2'd2
`define DISPATCH_TAG_LOAD   2'd3

`endif

// ==== logic/dispatch_pkg.sv ====
`include "dispatch_config.svh"

package dispatch_pkg;

    // one machine word, also the immediate width
    typedef logic [`DISPATCH_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [$clog2(`DISPATCH_NREGS)-1:0] reg_idx_t;

    // producer tag held in the register status table
    typedef logic [1:0] tag_t;

    // function unit select, also the bit index into fu_busy
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_t;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

`include "dispatch_config.svh"

module instr_decoder (
    input  dispatch_pkg::word_t    instr,
    output logic                   legal,
    output dispatch_pkg::fu_t      fu,
    output dispatch_pkg::reg_idx_t rd,
    output dispatch_pkg::reg_idx_t rs1,
    output dispatch_pkg::reg_idx_t rs2,
    output dispatch_pkg::word_t    imm,
    output logic                   writes_rd
);

    logic [6:0]          opcode;
    dispatch_pkg::word_t imm_i;
    dispatch_pkg::word_t imm_s;
    dispatch_pkg::word_t imm_b;
    dispatch_pkg::word_t imm_j;
    dispatch_pkg::word_t imm_u;

    assign opcode = instr[6:0];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{(`DISPATCH_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`DISPATCH_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`DISPATCH_XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(`DISPATCH_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        legal     = 1'b1;
        fu        = dispatch_pkg::FU_ALU;
        rd        = instr[11:7];
        rs1       = instr[19:15];
        rs2       = instr[24:20];
        imm       = '0;
        writes_rd = 1'b0;

        case (opcode)
            `DISPATCH_OP_OP: begin
                writes_rd = 1'b1;
            end
            `DISPATCH_OP_OP_IMM: begin
                rs2       = '0;
                imm       = imm_i;
                writes_rd = 1'b1;
            end
            `DISPATCH_OP_LUI: begin
                rs1       = '0;
                rs2       = '0;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            `DISPATCH_OP_LOAD: begin
                fu        = dispatch_pkg::FU_LDST;
                rs2       = '0;
                imm       = imm_i;
                writes_rd = 1'b1;
            end
            `DISPATCH_OP_STORE: begin
                fu  = dispatch_pkg::FU_LDST;
                rd  = '0;
                imm = imm_s;
            end
            `DISPATCH_OP_BRANCH: begin
                fu  = dispatch_pkg::FU_BRANCH;
                rd  = '0;
                imm = imm_b;
            end
            `DISPATCH_OP_JAL: begin
                fu        = dispatch_pkg::FU_BRANCH;
                rs1       = '0;
                rs2       = '0;
                imm       = imm_j;
                writes_rd = 1'b1;
            end
            `DISPATCH_OP_JALR: begin
                fu        = dispatch_pkg::FU_BRANCH;
                rs2       = '0;
                imm       = imm_i;
                writes_rd = 1'b1;
            end
            default: begin
                // outside the subset, consumed without issue
                legal = 1'b0;
                rd    = '0;
                rs1   = '0;
                rs2   = '0;
            end
        endcase
    end

endmodule

// ==== logic/reg_status_table.sv ====
`timescale 1ns/1ps

`include "dispatch_config.svh"

module reg_status_table (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   set_en,
    input  dispatch_pkg::reg_idx_t set_reg,
    input  dispatch_pkg::tag_t     set_tag,
    input  logic                   clr_en,
    input  dispatch_pkg::reg_idx_t clr_reg,
    input  dispatch_pkg::reg_idx_t rd_q,
    input  dispatch_pkg::reg_idx_t rs1_q,
    input  dispatch_pkg::reg_idx_t rs2_q,
    output logic                   rd_busy,
    output dispatch_pkg::tag_t     rs1_tag,
    output dispatch_pkg::tag_t     rs2_tag
);

    // one busy bit and producer tag per architectural register
    logic               busy [`DISPATCH_NREGS];
    dispatch_pkg::tag_t tag  [`DISPATCH_NREGS];

    logic set_hit;

    // x0 is hardwired, never tracked
    assign set_hit = set_en && (set_reg != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '{default: 1'b0};
            tag  <= '{default: `DISPATCH_TAG_NONE};
        end else begin
            if (clr_en) begin
                busy[clr_reg] <= 1'b0;
                tag[clr_reg]  <= `DISPATCH_TAG_NONE;
            end
            // a new producer overrides a writeback to the same register
            if (set_hit) begin
                busy[set_reg] <= 1'b1;
                tag[set_reg]  <= set_tag;
            end
        end
    end

    // combinational lookups for the instruction being dispatched
    assign rd_busy = busy[rd_q];
    assign rs1_tag = tag[rs1_q];
    assign rs2_tag = tag[rs2_q];

endmodule

// ==== logic/issue_control.sv ====
`timescale 1ns/1ps

`include "dispatch_config.svh"

module issue_control (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   instr_valid,
    input  logic                   branch_miss,
    input  logic [2:0]             fu_busy,
    input  logic                   legal,
    input  logic                   writes_rd,
    input  dispatch_pkg::fu_t      fu,
    input  dispatch_pkg::reg_idx_t rd,
    input  dispatch_pkg::reg_idx_t rs1,
    input  dispatch_pkg::reg_idx_t rs2,
    input  dispatch_pkg::word_t    imm,
    input  logic                   rd_busy,
    input  dispatch_pkg::tag_t     rs1_tag,
    input  dispatch_pkg::tag_t     rs2_tag,
    input  logic                   wb_en,
    input  dispatch_pkg::reg_idx_t wb_reg,
    output logic                   freeze,
    output logic                   accept,
    output dispatch_pkg::tag_t     set_tag,
    output logic                   issue_valid,
    output dispatch_pkg::fu_t      issue_fu,
    output dispatch_pkg::reg_idx_t issue_rd,
    output dispatch_pkg::reg_idx_t issue_rs1,
    output dispatch_pkg::reg_idx_t issue_rs2,
    output dispatch_pkg::word_t    issue_imm,
    output dispatch_pkg::tag_t     issue_t1,
    output dispatch_pkg::tag_t     issue_t2
);

    logic               unit_busy;
    logic               waw;
    logic               hazard;
    dispatch_pkg::tag_t t1;
    dispatch_pkg::tag_t t2;

    // structural hazard on the target unit
    assign unit_busy = fu_busy[fu];

    // x0 never reads busy, so stores and branches pass
    assign waw    = writes_rd && rd_busy;
    assign hazard = unit_busy || waw;

    assign freeze = instr_valid && legal && hazard;
    assign accept = instr_valid && legal && !hazard && !branch_miss;

    // producer code written into the table for rd
    always_comb begin
        case (fu)
            dispatch_pkg::FU_ALU:    set_tag = `DISPATCH_TAG_ALU;
            dispatch_pkg::FU_LDST:   set_tag = `DISPATCH_TAG_LOAD;
            dispatch_pkg::FU_BRANCH: set_tag = `DISPATCH_TAG_BRANCH;
            default:                 set_tag = `DISPATCH_TAG_NONE;
        endcase
    end

    // value arriving at writeback this edge is ready, drop the tag
    assign t1 = (wb_en && (wb_reg == rs1)) ? `DISPATCH_TAG_NONE : rs1_tag;
    assign t2 = (wb_en && (wb_reg == rs2)) ? `DISPATCH_TAG_NONE : rs2_tag;

    // a miss squashes the slot since accept is low then
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            issue_fu  <= fu;
            issue_rd  <= rd;
            issue_rs1 <= rs1;
            issue_rs2 <= rs2;
            issue_imm <= imm;
            issue_t1  <= t1;
            issue_t2  <= t2;
        end
    end

endmodule

// ==== logic/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dispatch_pkg::word_t    instr,
    input  logic                   instr_valid,
    input  logic [2:0]             fu_busy,
    input  logic                   wb_en,
    input  dispatch_pkg::reg_idx_t wb_reg,
    input  logic                   branch_miss,
    output logic                   freeze,
    output logic                   issue_valid,
    output dispatch_pkg::fu_t      issue_fu,
    output dispatch_pkg::reg_idx_t issue_rd,
    output dispatch_pkg::reg_idx_t issue_rs1,
    output dispatch_pkg::reg_idx_t issue_rs2,
    output dispatch_pkg::word_t    issue_imm,
    output dispatch_pkg::tag_t     issue_t1,
    output dispatch_pkg::tag_t     issue_t2
);

    logic                   legal;
    logic                   writes_rd;
    dispatch_pkg::fu_t      fu;
    dispatch_pkg::reg_idx_t rd;
    dispatch_pkg::reg_idx_t rs1;
    dispatch_pkg::reg_idx_t rs2;
    dispatch_pkg::word_t    imm;
    logic                   rd_busy;
    dispatch_pkg::tag_t     rs1_tag;
    dispatch_pkg::tag_t     rs2_tag;
    logic                   accept;
    logic                   set_en;
    dispatch_pkg::tag_t     set_tag;

    // only producers that move forward claim rd
    assign set_en = accept && writes_rd;

    instr_decoder u_decoder (
        .instr     (instr),
        .legal     (legal),
        .fu        (fu),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .writes_rd (writes_rd)
    );

    reg_status_table u_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (set_en),
        .set_reg (rd),
        .set_tag (set_tag),
        .clr_en  (wb_en),
        .clr_reg (wb_reg),
        .rd_q    (rd),
        .rs1_q   (rs1),
        .rs2_q   (rs2),
        .rd_busy (rd_busy),
        .rs1_tag (rs1_tag),
        .rs2_tag (rs2_tag)
    );

    issue_control u_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .branch_miss (branch_miss),
        .fu_busy     (fu_busy),
        .legal       (legal),
        .writes_rd   (writes_rd),
        .fu          (fu),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .rd_busy     (rd_busy),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .freeze      (freeze),
        .accept      (accept),
        .set_tag     (set_tag),
        .issue_valid (issue_valid),
        .issue_fu    (issue_fu),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_imm   (issue_imm),
        .issue_t1    (issue_t1),
        .issue_t2    (issue_t2)
    );

endmodule

// ==== tests/dispatch_checker.sv ====
`timescale 1ns/1ps

module dispatch_checker (
    input logic CLK,
    input logic nRST,
    input logic instr_valid,
    input logic freeze,
    input logic issue_valid,
    input logic branch_miss
);

    // a frozen slot never reaches the issue port
    freeze_blocks_issue: assert property (
        @(posedge CLK) disable iff (!nRST) freeze |=> !issue_valid
    ) else $error("issue_valid rose in the cycle after a frozen cycle");

    // no stall without an instruction to stall
    freeze_needs_valid: assert property (
        @(posedge CLK) disable iff (!nRST) !instr_valid |-> !freeze
    ) else $error("freeze high while instr_valid is low");

    // squash empties the issue slot
    miss_clears_issue: assert property (
        @(posedge CLK) disable iff (!nRST) branch_miss |=> !issue_valid
    ) else $error("issue_valid high in the cycle after branch_miss");

endmodule

// ==== tests/dispatch_tb.sv ====
`timescale 1ns/1ps

`include "dispatch_config.svh"

module dispatch_tb;

    typedef struct packed {
        logic        valid;
        logic [1:0]  fu;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [1:0]  t1;
        logic [1:0]  t2;
    } issue_exp_t;

    typedef struct packed {
        logic [31:0] instr;
        logic        valid;
        logic [2:0]  fu_busy;
        logic        wb_en;
        logic [4:0]  wb_reg;
        logic        miss;
        logic        freeze;
        issue_exp_t  want;
    } row_t;

    localparam logic [1:0] u_alu  = dispatch_pkg::FU_ALU;
    localparam logic [1:0] u_ldst = dispatch_pkg::FU_LDST;
    localparam logic [1:0] u_br   = dispatch_pkg::FU_BRANCH;
    localparam logic [6:0] op_imm  = `DISPATCH_OP_OP_IMM;
    localparam logic [6:0] op_load = `DISPATCH_OP_LOAD;
    localparam logic [6:0] op_jalr = `DISPATCH_OP_JALR;

    logic                   CLK = 1'b0;
    logic                   nRST;
    dispatch_pkg::word_t    instr;
    logic                   instr_valid;
    logic [2:0]             fu_busy;
    logic                   wb_en;
    dispatch_pkg::reg_idx_t wb_reg;
    logic                   branch_miss;
    logic                   freeze;
    logic                   issue_valid;
    dispatch_pkg::fu_t      issue_fu;
    dispatch_pkg::reg_idx_t issue_rd;
    dispatch_pkg::reg_idx_t issue_rs1;
    dispatch_pkg::reg_idx_t issue_rs2;
    dispatch_pkg::word_t    issue_imm;
    dispatch_pkg::tag_t     issue_t1;
    dispatch_pkg::tag_t     issue_t2;

    row_t       rows [$];
    // scoreboard copy of the register status table
    logic       model_busy [32];
    logic [1:0] model_tag [32];
    int         errors;
    int         checks;
    integer     seed;

    always #20 CLK = ~CLK;

    dispatch dut (.*);

    bind dispatch dispatch_checker chk (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .freeze      (freeze),
        .issue_valid (issue_valid),
        .branch_miss (branch_miss)
    );

    // RV32I encoders
    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, `DISPATCH_OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `DISPATCH_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `DISPATCH_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `DISPATCH_OP_LUI};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `DISPATCH_OP_JAL};
    endfunction

    function automatic logic [1:0] producer_tag(input logic [1:0] fu);
        case (fu)
            u_ldst:  return `DISPATCH_TAG_LOAD;
            u_br:    return `DISPATCH_TAG_BRANCH;
            default: return `DISPATCH_TAG_ALU;
        endcase
    endfunction

    // tag seen at the accepting edge, writeback of the same edge wins
    function automatic logic [1:0] expected_tag(input logic [4:0] src, input logic wbe,
                                                input logic [4:0] wbr);
        if (src == 5'd0 || (wbe && wbr == src)) begin
            return `DISPATCH_TAG_NONE;
        end
        return model_tag[src];
    endfunction

    task automatic update_model(input logic wbe, input logic [4:0] wbr, input logic set,
                                input logic [4:0] rd, input logic [1:0] fu);
        if (wbe) begin
            model_busy[wbr] = 1'b0;
            model_tag[wbr]  = `DISPATCH_TAG_NONE;
        end
        if (set && rd != 5'd0) begin
            model_busy[rd] = 1'b1;
            model_tag[rd]  = producer_tag(fu);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    task automatic check_issue(input issue_exp_t e);
        compare("issue_valid", 32'(issue_valid), 32'(e.valid));
        if (e.valid) begin
            compare("issue_fu", 32'(issue_fu), 32'(e.fu));
            compare("issue_rd", 32'(issue_rd), 32'(e.rd));
            compare("issue_rs1", 32'(issue_rs1), 32'(e.rs1));
            compare("issue_rs2", 32'(issue_rs2), 32'(e.rs2));
            compare("issue_imm", issue_imm, e.imm);
            compare("issue_t1", 32'(issue_t1), 32'(e.t1));
            compare("issue_t2", 32'(issue_t2), 32'(e.t2));
        end
    endtask

    task automatic add_row(input logic [31:0] ins, input logic v, input logic [2:0] busy,
                           input logic wbe, input logic [4:0] wbr, input logic miss,
                           input logic frz, input logic iss, input logic [1:0] fu,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm);
        row_t r;
        r = '0;
        r.instr      = ins;
        r.valid      = v;
        r.fu_busy    = busy;
        r.wb_en      = wbe;
        r.wb_reg     = wbr;
        r.miss       = miss;
        r.freeze     = frz;
        r.want.valid = iss;
        r.want.fu    = fu;
        r.want.rd    = rd;
        r.want.rs1   = rs1;
        r.want.rs2   = rs2;
        r.want.imm   = imm;
        rows.push_back(r);
    endtask

    // instr, valid, fu_busy, wb_en, wb_reg, miss, freeze, issue, fu, rd, rs1, rs2, imm
    task automatic build_table();
        add_row(32'h0, 0, 3'd0, 0, 0, 0, 0, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_r(3, 1, 2), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 3, 1, 2, 32'h0);
        add_row(enc_i(op_imm, 4, 1, 12'hffb), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 4, 1, 0, 32'hfffffffb);
        add_row(enc_u(6, 20'h12345), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 6, 0, 0, 32'h12345000);
        add_row(enc_i(op_load, 8, 2, 12'h010), 1, 3'd0, 0, 0, 0, 0, 1, u_ldst, 8, 2, 0, 32'h10);
        add_row(enc_s(2, 3, 12'hff8), 1, 3'd0, 0, 0, 0, 0, 1, u_ldst, 0, 2, 3, 32'hfffffff8);
        add_row(enc_b(1, 4, 13'h1ff0), 1, 3'd0, 0, 0, 0, 0, 1, u_br, 0, 1, 4, 32'hfffffff0);
        add_row(enc_j(9, 21'h1a8800), 1, 3'd0, 0, 0, 0, 0, 1, u_br, 9, 0, 0, 32'hfffa8800);
        add_row(enc_i(op_jalr, 10, 8, 12'h004), 1, 3'd0, 0, 0, 0, 0, 1, u_br, 10, 8, 0, 32'h4);
        // opcode outside the subset
        add_row(32'h0000007f, 1, 3'b111, 0, 0, 0, 0, 0, u_alu, 0, 0, 0, 32'h0);
        // second write to x5 waits for its writeback
        add_row(enc_r(5, 1, 2), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 5, 1, 2, 32'h0);
        add_row(enc_i(op_imm, 5, 5, 12'h001), 1, 3'd0, 0, 0, 0, 1, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_i(op_imm, 5, 5, 12'h001), 1, 3'd0, 0, 0, 0, 1, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_i(op_imm, 5, 5, 12'h001), 1, 3'd0, 1, 5, 0, 1, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_i(op_imm, 5, 5, 12'h001), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 5, 5, 0, 32'h1);
        // load/store unit busy
        add_row(enc_r(11, 1, 2), 1, 3'b010, 0, 0, 0, 0, 1, u_alu, 11, 1, 2, 32'h0);
        add_row(enc_i(op_load, 7, 2, 12'h000), 1, 3'b010, 0, 0, 0, 1, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_i(op_load, 7, 2, 12'h000), 1, 3'b010, 0, 0, 0, 1, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_i(op_load, 7, 2, 12'h000), 1, 3'd0, 0, 0, 0, 0, 1, u_ldst, 7, 2, 0, 32'h0);
        // readers of pending producers
        add_row(enc_r(12, 7, 0), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 12, 7, 0, 32'h0);
        add_row(enc_j(1, 21'h8), 1, 3'd0, 0, 0, 0, 0, 1, u_br, 1, 0, 0, 32'h8);
        add_row(enc_r(13, 1, 7), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 13, 1, 7, 32'h0);
        add_row(enc_r(14, 7, 7), 1, 3'd0, 1, 7, 0, 0, 1, u_alu, 14, 7, 7, 32'h0);
        // squash, then the same rd goes through
        add_row(enc_r(16, 2, 2), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 16, 2, 2, 32'h0);
        add_row(enc_r(15, 1, 2), 1, 3'd0, 0, 0, 1, 0, 0, u_alu, 0, 0, 0, 32'h0);
        add_row(enc_r(15, 1, 2), 1, 3'd0, 0, 0, 0, 0, 1, u_alu, 15, 1, 2, 32'h0);
        add_row(32'h0, 0, 3'd0, 0, 0, 0, 0, 0, u_alu, 0, 0, 0, 32'h0);
    endtask

    // ALU op with random registers, WAW cleared by writeback
    task automatic run_random(input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, output logic timed_out);
        int         tries;
        issue_exp_t e;
        tries     = 0;
        timed_out = 1'b0;
        @(posedge CLK);
        instr       <= enc_r(rd, rs1, rs2);
        instr_valid <= 1'b1;
        @(negedge CLK);
        compare("freeze", 32'(freeze), 32'(rd != 5'd0 && model_busy[rd]));
        while (freeze && tries < 8) begin
            @(posedge CLK);
            wb_en  <= 1'b1;
            wb_reg <= rd;
            @(posedge CLK);
            wb_en <= 1'b0;
            update_model(1'b1, rd, 1'b0, rd, u_alu);
            @(negedge CLK);
            tries++;
        end
        if (freeze) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: freeze stayed high for x%0d after its writeback", rd);
        end else begin
            e       = '0;
            e.valid = 1'b1;
            e.fu    = u_alu;
            e.rd    = rd;
            e.rs1   = rs1;
            e.rs2   = rs2;
            e.t1    = expected_tag(rs1, 1'b0, 5'd0);
            e.t2    = expected_tag(rs2, 1'b0, 5'd0);
            @(posedge CLK);
            instr_valid <= 1'b0;
            update_model(1'b0, 5'd0, 1'b1, rd, u_alu);
            @(negedge CLK);
            check_issue(e);
        end
    endtask

    initial begin
        issue_exp_t  pend;
        issue_exp_t  cur;
        row_t        r;
        logic [31:0] rnd;
        logic        timed_out;
        errors    = 0;
        checks    = 0;
        seed      = 32'h2ee2_9408;
        timed_out = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_busy[i] = 1'b0;
            model_tag[i]  = `DISPATCH_TAG_NONE;
        end
        nRST        <= 1'b0;
        instr       <= '0;
        instr_valid <= 1'b0;
        fu_busy     <= '0;
        wb_en       <= 1'b0;
        wb_reg      <= '0;
        branch_miss <= 1'b0;
        build_table();
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        // issue of each row is checked one cycle later
        pend = '0;
        foreach (rows[i]) begin
            r = rows[i];
            @(posedge CLK);
            instr       <= r.instr;
            instr_valid <= r.valid;
            fu_busy     <= r.fu_busy;
            wb_en       <= r.wb_en;
            wb_reg      <= r.wb_reg;
            branch_miss <= r.miss;
            cur    = r.want;
            cur.t1 = expected_tag(cur.rs1, r.wb_en, r.wb_reg);
            cur.t2 = expected_tag(cur.rs2, r.wb_en, r.wb_reg);
            update_model(r.wb_en, r.wb_reg, r.want.valid, r.want.rd, r.want.fu);
            @(negedge CLK);
            compare("freeze", 32'(freeze), 32'(r.freeze));
            check_issue(pend);
            pend = cur;
        end

        for (int n = 0; n < 12 && !timed_out; n++) begin
            rnd = $random(seed);
            run_random(rnd[4:0], rnd[9:5], rnd[14:10], timed_out);
        end

        $display("dispatch_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/dispatch_pkg.sv
logic/instr_decoder.sv
logic/reg_status_table.sv
logic/issue_control.sv
logic/dispatch.sv
tests/dispatch_checker.sv
tests/dispatch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module dispatch_tb -Mdir obj_dir -o dispatch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dispatch_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'test passed'; then
    exit 0
fi
exit 1
